//--- exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
  input  rv_exec_pkg::decoded_t i_dec,
  output logic [31:0]           o_result
);
  import rv_exec_pkg::*;

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [4:0]  shamt;

  // auipc adds to the pc, immediate forms replace rs2
  assign op_a  = i_dec.ctrl.op_a_pc ? i_dec.pc : i_dec.rs1_data;
  assign op_b  = i_dec.ctrl.op_b_imm ? i_dec.imm : i_dec.rs2_data;
  assign shamt = op_b[4:0];  // rv32i shifts by at most 31

  always_comb begin
    case (i_dec.ctrl.alu_op)
      alu_add:  o_result = op_a + op_b;
      alu_sub:  o_result = op_a - op_b;
      alu_sll:  o_result = op_a << shamt;
      alu_slt:  o_result = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu: o_result = {31'b0, op_a < op_b};
      alu_xor:  o_result = op_a ^ op_b;
      alu_srl:  o_result = op_a >> shamt;
      alu_sra:  o_result = $unsigned($signed(op_a) >>> shamt);  // sign bit shifted in
      alu_or:   o_result = op_a | op_b;
      alu_and:  o_result = op_a & op_b;
      default:  o_result = op_a + op_b;  // unused encodings fall back to add
    endcase
  end

endmodule

//--- exec_branch.sv
`timescale 1ns/1ps

module exec_branch (
  input  rv_exec_pkg::decoded_t   i_dec,
  output rv_exec_pkg::branch_res_t o_res
);
  import rv_exec_pkg::*;

  logic        cond;
  logic [31:0] target;
  logic [31:0] link;
  logic        taken;

  // the compare only matters for conditional branches
  always_comb begin
    case (i_dec.funct3)
      f3_beq:  cond = i_dec.rs1_data == i_dec.rs2_data;
      f3_bne:  cond = i_dec.rs1_data != i_dec.rs2_data;
      f3_blt:  cond = $signed(i_dec.rs1_data) < $signed(i_dec.rs2_data);
      f3_bge:  cond = $signed(i_dec.rs1_data) >= $signed(i_dec.rs2_data);
      f3_bltu: cond = i_dec.rs1_data < i_dec.rs2_data;
      f3_bgeu: cond = i_dec.rs1_data >= i_dec.rs2_data;
      default: cond = 1'b0;  // reserved codes were already flagged illegal
    endcase
  end

  // jalr is register relative with bit 0 dropped, everything else pc relative
  always_comb begin
    if (i_dec.ctrl.is_jalr) target = (i_dec.rs1_data + i_dec.imm) & ~32'd1;
    else target = i_dec.pc + i_dec.imm;
  end

  assign link  = i_dec.pc + 32'd4;
  assign taken = i_dec.ctrl.is_jal | i_dec.ctrl.is_jalr | (i_dec.ctrl.is_branch & cond);

  assign o_res.next_pc    = taken ? target : link;
  assign o_res.link       = link;
  assign o_res.taken      = taken;
  assign o_res.misaligned = taken & target[1];  // bit 0 is always clear here

endmodule

//--- exec_decode.sv
`timescale 1ns/1ps

module exec_decode (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_advance,
  input  logic                   i_valid,
  input  rv_exec_pkg::exec_req_t i_req,
  output logic                   o_valid,
  output rv_exec_pkg::decoded_t  o_dec
);
  import rv_exec_pkg::*;

  instr_u      instr;
  u_fmt_t      u_view;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] imm;
  logic        wr_en;
  exec_ctrl_t  ctrl;
  decoded_t    dec_d;

  // maps funct3 to the alu operation, alt picks sub or sra
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      f3_add_sub: alu_sel = alt ? alu_sub : alu_add;
      f3_sll:     alu_sel = alu_sll;
      f3_slt:     alu_sel = alu_slt;
      f3_sltu:    alu_sel = alu_sltu;
      f3_xor:     alu_sel = alu_xor;
      f3_srl_sra: alu_sel = alt ? alu_sra : alu_srl;
      f3_or:      alu_sel = alu_or;
      f3_and:     alu_sel = alu_and;
      default:    alu_sel = alu_add;
    endcase
  endfunction

  assign instr  = i_req.instr;
  assign u_view = u_fmt_t'(instr.raw);  // u format only carries the upper immediate

  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_u = {u_view.imm, 12'b0};
  assign imm_b = {{20{instr.raw[31]}}, instr.raw[7], instr.raw[30:25], instr.raw[11:8], 1'b0};
  assign imm_j = {{12{instr.raw[31]}}, instr.raw[19:12], instr.raw[20], instr.raw[30:21], 1'b0};

  always_comb begin
    ctrl        = '0;  // add, rs1 and rs2 operands, alu write data
    ctrl.alu_op = alu_add;
    ctrl.wb_sel = wb_alu;
    wr_en       = 1'b0;
    imm         = imm_i;
    case (instr.r.opcode)
      opc_op: begin
        wr_en       = 1'b1;
        ctrl.alu_op = alu_sel(instr.r.funct3, instr.r.funct7[5]);
        // only sub and sra may use the alternate funct7
        ctrl.illegal = !(instr.r.funct7 == f7_base ||
                         (instr.r.funct7 == f7_alt &&
                          (instr.r.funct3 == f3_add_sub || instr.r.funct3 == f3_srl_sra)));
      end
      opc_op_imm: begin
        wr_en         = 1'b1;
        ctrl.op_b_imm = 1'b1;
        ctrl.alu_op   = alu_sel(instr.r.funct3,
                                instr.r.funct3 == f3_srl_sra && instr.r.funct7[5]);
        if (instr.r.funct3 == f3_sll)
          ctrl.illegal = instr.r.funct7 != f7_base;  // upper shamt bits must be zero
        else if (instr.r.funct3 == f3_srl_sra)
          ctrl.illegal = instr.r.funct7 != f7_base && instr.r.funct7 != f7_alt;
      end
      opc_lui: begin
        wr_en       = 1'b1;
        imm         = imm_u;
        ctrl.wb_sel = wb_imm;
      end
      opc_auipc: begin
        wr_en         = 1'b1;
        imm           = imm_u;
        ctrl.op_a_pc  = 1'b1;  // pc + upper immediate through the adder
        ctrl.op_b_imm = 1'b1;
      end
      opc_branch: begin
        imm            = imm_b;
        ctrl.is_branch = 1'b1;
        ctrl.illegal   = instr.r.funct3[2:1] == 2'b01;  // reserved compare codes
      end
      opc_jal: begin
        wr_en       = 1'b1;
        imm         = imm_j;
        ctrl.is_jal = 1'b1;
        ctrl.wb_sel = wb_link;
      end
      opc_jalr: begin
        wr_en        = 1'b1;
        ctrl.is_jalr = 1'b1;
        ctrl.wb_sel  = wb_link;
        ctrl.illegal = instr.i.funct3 != 3'b000;
      end
      opc_system: begin
        if (instr.raw == ebreak_word) ctrl.halt = 1'b1;  // ebreak halts the hart
        else ctrl.illegal = 1'b1;  // ecall and csr access are not supported
      end
      default: ctrl.illegal = 1'b1;
    endcase
    // an illegal word keeps no side effects, only the flag survives
    if (ctrl.illegal) begin
      ctrl         = '0;
      ctrl.illegal = 1'b1;
    end else if (wr_en) begin
      ctrl.rd = instr.r.rd;  // writes to x0 come out as rd 0 anyway
    end
  end

  assign dec_d = '{ctrl: ctrl, funct3: instr.r.funct3, pc: i_req.pc,
                   rs1_data: i_req.rs1_data, rs2_data: i_req.rs2_data,
                   imm: imm, instr: instr.raw};

  always_ff @(posedge i_clk) begin
    if (i_rst) o_valid <= 1'b0;
    else if (i_advance) o_valid <= i_valid;  // a bubble is loaded when nothing is offered
  end

  always_ff @(posedge i_clk) begin
    if (i_advance) o_dec <= dec_d;
  end

endmodule

//--- exec_retire.sv
`timescale 1ns/1ps

module exec_retire (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_advance,
  input  logic                     i_valid,
  input  rv_exec_pkg::decoded_t    i_dec,
  input  logic [31:0]              i_alu_result,
  input  rv_exec_pkg::branch_res_t i_branch,
  output logic                     o_valid,
  output rv_exec_pkg::exec_resp_t  o_resp
);
  import rv_exec_pkg::*;

  logic        trap;
  logic [31:0] rd_data;
  exec_resp_t  resp_d;

  always_comb begin
    case (i_dec.ctrl.wb_sel)
      wb_link: rd_data = i_branch.link;  // return address of jal and jalr
      wb_imm:  rd_data = i_dec.imm;      // lui writes the upper immediate directly
      default: rd_data = i_alu_result;
    endcase
  end

  // an illegal word or a misaligned taken target both end in a trap
  assign trap = i_dec.ctrl.illegal | i_branch.misaligned;

  always_comb begin
    resp_d.instr   = i_dec.instr;
    resp_d.pc      = i_dec.pc;
    resp_d.rd_data = rd_data;
    resp_d.trap    = trap;
    resp_d.halt    = i_dec.ctrl.halt;
    // a trapping instruction writes nothing and falls through to pc+4
    resp_d.rd_addr = trap ? 5'd0 : i_dec.ctrl.rd;
    resp_d.next_pc = (i_branch.taken && !trap) ? i_branch.next_pc : i_branch.link;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) o_valid <= 1'b0;
    else if (i_advance) o_valid <= i_valid;
  end

  always_ff @(posedge i_clk) begin
    if (i_advance) o_resp <= resp_d;  // holds while the consumer stalls
  end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_rv_exec -f sources.f -o sim_rv_exec
./obj_dir/sim_rv_exec > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
exit 0

//--- rv_exec_assert.sv
`timescale 1ns/1ps

module rv_exec_assert (
  input logic                    i_clk,
  input logic                    i_rst,
  input logic                    i_out_valid,  // the top level's o_out_valid
  input logic                    i_out_ready,
  input rv_exec_pkg::exec_resp_t i_out         // the top level's o_out
);

  // the retire register comes out of reset empty
  reset_empty: assert property (@(posedge i_clk) i_rst |=> !i_out_valid)
    else $error("o_out_valid high in the cycle after reset");

  // a record that is not taken stays exactly where it is
  stall_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out))
    else $error("o_out or o_out_valid changed while the consumer stalled");

  trap_no_write: assert property (@(posedge i_clk) disable iff (i_rst)
    i_out_valid && i_out.trap |-> i_out.rd_addr == 5'd0)
    else $error("trapping record writes a register");

endmodule

bind rv_exec_top rv_exec_assert rv_exec_assert_inst (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_out_valid (o_out_valid),
  .i_out_ready (i_out_ready),
  .i_out       (o_out)
);

//--- rv_exec_pkg.sv
package rv_exec_pkg;

  // major opcodes of the kept rv32i instruction classes
  localparam logic [6:0] opc_op     = 7'b0110011;  // register-register alu
  localparam logic [6:0] opc_op_imm = 7'b0010011;  // register-immediate alu
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_system = 7'b1110011;  // only ebreak is accepted here

  localparam logic [31:0] ebreak_word = 32'h00100073;

  // funct3 of the integer alu group
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 of the conditional branches, 010 and 011 are reserved
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;  // selects sub and sra

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  // source of the destination register write data
  typedef enum logic [1:0] {
    wb_alu  = 2'd0,
    wb_link = 2'd1,  // pc+4 for jal and jalr
    wb_imm  = 2'd2   // upper immediate for lui
  } wb_sel_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // one instruction word seen through the raw, r and i views
  typedef union packed {
    logic [31:0] raw;
    r_fmt_t      r;
    i_fmt_t      i;
  } instr_u;

  typedef struct packed {
    instr_u      instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
  } exec_req_t;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       op_a_pc;   // operand a is the pc instead of rs1
    logic       op_b_imm;  // operand b is the immediate instead of rs2
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    wb_sel_e    wb_sel;
    logic [4:0] rd;        // zero when the instruction writes nothing
    logic       illegal;
    logic       halt;
  } exec_ctrl_t;

  typedef struct packed {
    exec_ctrl_t  ctrl;
    logic [2:0]  funct3;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm;
    logic [31:0] instr;
  } decoded_t;

  typedef struct packed {
    logic [31:0] next_pc;
    logic [31:0] link;
    logic        taken;
    logic        misaligned;
  } branch_res_t;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        trap;
    logic        halt;
  } exec_resp_t;

endpackage

//--- rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_in_valid,
  output logic                    o_in_ready,
  input  rv_exec_pkg::exec_req_t  i_in,
  output logic                    o_out_valid,
  input  logic                    i_out_ready,
  output rv_exec_pkg::exec_resp_t o_out
);
  import rv_exec_pkg::*;

  logic        advance;
  logic        dec_valid;
  decoded_t    dec;
  logic [31:0] alu_result;
  branch_res_t br_res;

  // the whole pipe moves when the retire slot is free or drains this cycle
  assign advance    = !o_out_valid | i_out_ready;
  assign o_in_ready = advance;

  exec_decode exec_decode_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_advance (advance),
    .i_valid   (i_in_valid),
    .i_req     (i_in),
    .o_valid   (dec_valid),
    .o_dec     (dec)
  );

  // alu and branch resolver both work on the registered bundle in parallel
  exec_alu exec_alu_inst (
    .i_dec    (dec),
    .o_result (alu_result)
  );

  exec_branch exec_branch_inst (
    .i_dec (dec),
    .o_res (br_res)
  );

  exec_retire exec_retire_inst (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_advance    (advance),
    .i_valid      (dec_valid),
    .i_dec        (dec),
    .i_alu_result (alu_result),
    .i_branch     (br_res),
    .o_valid      (o_out_valid),
    .o_resp       (o_out)
  );

endmodule

//--- sources.f
rv_exec_pkg.sv
exec_decode.sv
exec_alu.sv
exec_branch.sv
exec_retire.sv
rv_exec_top.sv
rv_exec_assert.sv
tb_rv_exec.sv

//--- tb_rv_exec.sv
`timescale 1ns/1ps

module tb_rv_exec;
  import rv_exec_pkg::*;

  logic       i_clk;
  logic       i_rst;
  logic       i_in_valid;
  logic       o_in_ready;
  exec_req_t  i_in;
  logic       o_out_valid;
  logic       i_out_ready;
  exec_resp_t o_out;

  integer seed;
  int     val_errs;    // wrong values on the outputs
  int     proto_errs;  // timeouts, lost or extra results, wrong latency

  rv_exec_top rv_exec_top_inst (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .i_in        (i_in),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .o_out       (o_out)
  );

  always #2 i_clk = ~i_clk;  // 4 ns period

  // instruction encoders, rs1 and rs2 fields are fixed since the data comes in already read
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {imm, 5'd1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  function automatic exec_req_t make_req(input logic [31:0] w, input logic [31:0] pc,
                                         input logic [31:0] a, input logic [31:0] b);
    exec_req_t q;
    q.instr.raw = w;
    q.pc        = pc;
    q.rs1_data  = a;
    q.rs2_data  = b;
    return q;
  endfunction

  // signed less than from the sign bits, unsigned compare when the signs agree
  function automatic logic lt_signed(input logic [31:0] a, input logic [31:0] b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  // reference model of one instruction, built straight from the rv32i rules
  function automatic exec_resp_t model_exec(input exec_req_t q);
    exec_resp_t  r;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] tgt;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic        take;
    logic        wr;
    logic        bad;
    w     = q.instr.raw;
    f7    = w[31:25];
    f3    = w[14:12];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_u = {w[31:12], 12'h000};
    a     = q.rs1_data;
    b     = (w[6:0] == opc_op_imm) ? imm_i : q.rs2_data;
    r         = '0;
    r.instr   = w;
    r.pc      = q.pc;
    take      = 1'b0;
    wr        = 1'b1;
    bad       = 1'b0;
    tgt       = q.pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};  // branch target
    case (w[6:0])
      opc_op, opc_op_imm: begin
        if (w[6:0] == opc_op)
          bad = f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        else if (f3 == 3'd1)
          bad = f7 != 7'h00;
        else if (f3 == 3'd5)
          bad = f7 != 7'h00 && f7 != 7'h20;
        case (f3)
          3'd0: r.rd_data = (w[6:0] == opc_op && f7[5]) ? a - b : a + b;
          3'd1: r.rd_data = a << b[4:0];
          3'd2: r.rd_data = {31'd0, lt_signed(a, b)};
          3'd3: r.rd_data = {31'd0, a < b};
          3'd4: r.rd_data = a ^ b;
          3'd5: r.rd_data = (a >> b[4:0]) |
                            ((f7[5] && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
          3'd6: r.rd_data = a | b;
          default: r.rd_data = a & b;
        endcase
      end
      opc_lui:   r.rd_data = imm_u;
      opc_auipc: r.rd_data = q.pc + imm_u;
      opc_branch: begin
        wr = 1'b0;  // branches never write a register
        case (f3)
          3'd0: take = a == b;
          3'd1: take = a != b;
          3'd4: take = lt_signed(a, b);
          3'd5: take = !lt_signed(a, b);
          3'd6: take = a < b;
          3'd7: take = a >= b;
          default: bad = 1'b1;
        endcase
      end
      opc_jal: begin
        r.rd_data = q.pc + 32'd4;
        take      = 1'b1;
        tgt       = q.pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      opc_jalr: begin
        bad       = f3 != 3'd0;
        r.rd_data = q.pc + 32'd4;
        take      = 1'b1;
        tgt       = (a + imm_i) & 32'hffff_fffe;  // bit 0 is dropped
      end
      opc_system: begin
        wr = 1'b0;
        if (w == ebreak_word) r.halt = 1'b1;
        else bad = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    r.trap    = bad || (take && tgt[1]);  // misaligned when a taken target has bit 1 set
    r.next_pc = (take && !r.trap) ? tgt : q.pc + 32'd4;
    r.rd_addr = (wr && !r.trap) ? w[11:7] : 5'd0;
    return r;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
      val_errs++;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %0t ns %s expected %b actual %b", $time, name, exp, act);
      val_errs++;
    end
  endtask

  task automatic compare_resp(input exec_resp_t exp, input exec_resp_t act);
    compare_field("o_out.instr", exp.instr, act.instr);
    compare_field("o_out.pc", exp.pc, act.pc);
    compare_field("o_out.next_pc", exp.next_pc, act.next_pc);
    compare_field("o_out.rd_addr", {27'd0, exp.rd_addr}, {27'd0, act.rd_addr});
    if (exp.rd_addr != 5'd0)
      compare_field("o_out.rd_data", exp.rd_data, act.rd_data);  // data only counts when written
    compare_bit("o_out.trap", exp.trap, act.trap);
    compare_bit("o_out.halt", exp.halt, act.halt);
  endtask

  // one request through an otherwise empty pipe, the result is due two edges after acceptance
  task automatic send_req(input exec_req_t q);
    int n;
    @(posedge i_clk);
    i_in        <= q;
    i_in_valid  <= 1'b1;
    i_out_ready <= 1'b1;
    n = 0;
    @(negedge i_clk);
    while (!o_in_ready && n < 50) begin
      @(negedge i_clk);
      n++;
    end
    @(posedge i_clk);  // the transfer edge
    i_in_valid <= 1'b0;
    if (n >= 50) begin
      $display("timeout at %0t ns, o_in_ready never rose for pc %h", $time, q.pc);
      proto_errs++;
      return;
    end
    n = 1;
    @(negedge i_clk);
    while (!o_out_valid && n < 50) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_out_valid) begin
      $display("timeout at %0t ns, no result for pc %h", $time, q.pc);
      proto_errs++;
    end else begin
      if (n != 2) begin
        $display("result for pc %h came %0d cycles after acceptance instead of 2", q.pc, n);
        proto_errs++;
      end
      compare_resp(model_exec(q), o_out);
    end
  endtask

  task automatic test_alu();
    int          k;
    logic [11:0] imm;
    for (k = 0; k < 8; k++) begin
      // negative and positive operands so slt and sltu disagree
      send_req(make_req(enc_r(7'h00, k[2:0], 5'd5, opc_op), 32'h100, 32'hffff_fff0, 32'd5));
      send_req(make_req(enc_r(7'h00, k[2:0], 5'd6, opc_op), 32'h104, 32'd5, 32'h8000_0003));
      imm = (k == 1 || k == 5) ? 12'h003 : 12'hf85;  // shift immediates keep funct7 clear
      send_req(make_req(enc_i(imm, k[2:0], 5'd7, opc_op_imm), 32'h108, 32'h8000_00f0, 32'd0));
    end
    send_req(make_req(enc_r(7'h20, 3'd0, 5'd8, opc_op), 32'h10c, 32'd5, 32'd9));  // sub
    send_req(make_req(enc_r(7'h20, 3'd5, 5'd9, opc_op), 32'h110, 32'h8000_0100, 32'd4));
    send_req(make_req(enc_i(12'h405, 3'd5, 5'd10, opc_op_imm), 32'h114, 32'hf000_0000, 32'd0));
    send_req(make_req(enc_r(7'h00, 3'd0, 5'd0, opc_op), 32'h118, 32'd1, 32'd2));  // rd x0
  endtask

  task automatic test_upper();
    send_req(make_req({20'habcde, 5'd7, opc_lui}, 32'h1000, 32'd0, 32'd0));
    send_req(make_req({20'h12345, 5'd8, opc_auipc}, 32'h1004, 32'd0, 32'd0));
    send_req(make_req({20'hfffff, 5'd9, opc_auipc}, 32'h1008, 32'd0, 32'd0));  // wraps below pc
  endtask

  task automatic test_branch();
    int          k;
    int          p;
    logic [31:0] a;
    logic [31:0] b;
    // three operand pairs give every condition a taken and a not taken case
    for (k = 0; k < 8; k++) begin
      if (k != 2 && k != 3) begin
        for (p = 0; p < 3; p++) begin
          a = (p == 0) ? 32'hffff_ffff : (p == 1) ? 32'd3 : 32'd1;
          b = (p == 0) ? 32'd1 : (p == 1) ? 32'd3 : 32'hffff_ffff;
          send_req(make_req(enc_b(k[0] ? 13'h1ff8 : 13'h0040, k[2:0]), 32'h400, a, b));
        end
      end
    end
    send_req(make_req(enc_b(13'h0006, 3'd0), 32'h400, 32'd7, 32'd7));  // taken, misaligned
  endtask

  task automatic test_jump();
    send_req(make_req(enc_j(21'h000100, 5'd1), 32'h2000, 32'd0, 32'd0));
    send_req(make_req(enc_j(21'h1ffff0, 5'd1), 32'h2000, 32'd0, 32'd0));  // backward
    send_req(make_req(enc_j(21'h000102, 5'd1), 32'h2000, 32'd0, 32'd0));  // traps
    send_req(make_req(enc_i(12'h004, 3'd0, 5'd3, opc_jalr), 32'h2100, 32'h3001, 32'd0));
    send_req(make_req(enc_i(12'hffc, 3'd0, 5'd3, opc_jalr), 32'h2104, 32'h4000, 32'd0));
    send_req(make_req(enc_i(12'h002, 3'd0, 5'd3, opc_jalr), 32'h2108, 32'h3000, 32'd0));
  endtask

  task automatic test_illegal_halt();
    send_req(make_req(32'h0000_2083, 32'h600, 32'd1, 32'd2));  // lw is not kept
    send_req(make_req(enc_r(7'h01, 3'd0, 5'd4, opc_op), 32'h604, 32'd3, 32'd4));  // mul
    send_req(make_req(ebreak_word, 32'h608, 32'd0, 32'd0));
    send_req(make_req(32'h0000_0073, 32'h60c, 32'd0, 32'd0));  // ecall traps
  endtask

  task automatic make_rand_req(output exec_req_t q);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [6:0]  f7;
    logic [11:0] imm;
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    r4 = $random(seed);
    f7 = (r1[3] && (r1[2:0] == 3'd0 || r1[2:0] == 3'd5)) ? 7'h20 : 7'h00;
    imm = r1[31:20];
    if (r1[2:0] == 3'd1 || r1[2:0] == 3'd5) imm[11:5] = f7;  // keeps shift immediates legal
    if (r1[4]) q = make_req(enc_r(f7, r1[2:0], r1[9:5], opc_op), {r2[31:2], 2'b00}, r3, r4);
    else q = make_req(enc_i(imm, r1[2:0], r1[9:5], opc_op_imm), {r2[31:2], 2'b00}, r3, r4);
  endtask

  // random alu stream with random gaps on both sides, results are matched in order
  task automatic test_stream(input int count);
    exec_resp_t  exp_q[$];
    exec_req_t   q;
    logic [31:0] r;
    logic        in_fire;
    int          sent;
    int          got;
    int          cycles;
    int          k;
    sent    = 0;
    got     = 0;
    cycles  = 0;
    in_fire = 1'b0;
    while (got < count && cycles < count * 20) begin
      @(posedge i_clk);
      r = $random(seed);
      i_out_ready <= r[0];
      if (!i_in_valid || in_fire) begin  // valid only drops after a transfer
        if (sent < count && r[1]) begin
          make_rand_req(q);
          i_in       <= q;
          i_in_valid <= 1'b1;
        end else begin
          i_in_valid <= 1'b0;
        end
      end
      @(negedge i_clk);
      in_fire = i_in_valid && o_in_ready;
      if (in_fire) begin
        exp_q.push_back(model_exec(i_in));
        sent++;
      end
      if (o_out_valid && i_out_ready) begin
        if (exp_q.size() == 0) begin
          $display("result at %0t ns with no request outstanding", $time);
          proto_errs++;
        end else begin
          compare_resp(exp_q.pop_front(), o_out);
        end
        got++;
      end else if (o_out_valid) begin
        compare_bit("o_in_ready", 1'b0, o_in_ready);  // a held record blocks the input
      end
      cycles++;
    end
    @(posedge i_clk);
    i_in_valid  <= 1'b0;
    i_out_ready <= 1'b1;
    if (got < count || exp_q.size() != 0) begin
      $display("stream timed out, %0d of %0d results, %0d left", got, count, exp_q.size());
      proto_errs++;
    end
    for (k = 0; k < 3; k++) begin
      @(negedge i_clk);
      compare_bit("o_out_valid", 1'b0, o_out_valid);  // nothing extra after the stream
    end
  endtask

  initial begin
    seed        = 28263;
    val_errs    = 0;
    proto_errs  = 0;
    i_clk       = 1'b0;
    i_rst       = 1'b1;
    i_in_valid  = 1'b0;
    i_in        = '0;
    i_out_ready = 1'b0;
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);
    compare_bit("o_out_valid", 1'b0, o_out_valid);
    compare_bit("o_in_ready", 1'b1, o_in_ready);
    test_alu();
    test_upper();
    test_branch();
    test_jump();
    test_illegal_halt();
    test_stream(200);
    $display("errors: %0d value mismatches, %0d protocol errors", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
